// ==== design/pipe_config.svh ====
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// operand and register width
`define DATA_WIDTH      32

// eight architectural registers, r0 reads zero
`define REG_IDX_WIDTH   3

// immediate field, sign extended to DATA_WIDTH
`define IMM_WIDTH       16

// queue depth, also the sender's starting credit count
`define QUEUE_DEPTH     4

// data memory size in words
`define DMEM_WORDS      64

// instruction word width
`define INSTR_WIDTH     32

`endif

// ==== design/pipe_pkg.sv ====
`include "pipe_config.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_SLT  = 4'h6,     // signed compare
        OP_ADDI = 4'h7,
        OP_LW   = 4'h8,
        OP_SW   = 4'h9
    } opcode_e;

    typedef enum logic {
        HAZD_NORMAL = 1'b0, // capture the decode packet
        HAZD_NO_OP  = 1'b1  // load a bubble
    } hazd_ctl_e;

    typedef enum logic [1:0] {
        FWD_ID_EX  = 2'd0,  // value read in decode
        FWD_EX_MEM = 2'd1,  // alu result one ahead
        FWD_MEM_WB = 2'd2   // retiring value two ahead
    } fwd_sel_e;

    typedef struct packed {
        opcode_e                   opcode;  // [31:28]
        logic [`REG_IDX_WIDTH-1:0] rd;      // [27:25]
        logic [`REG_IDX_WIDTH-1:0] rs1;     // [24:22]
        logic [`REG_IDX_WIDTH-1:0] rs2;     // [21:19]
        logic [`INSTR_WIDTH-4-3*`REG_IDX_WIDTH-`IMM_WIDTH-1:0] rsvd; // [18:16] unused
        logic [`IMM_WIDTH-1:0]     imm;     // [15:0]
    } instr_t;

    typedef struct packed {
        logic                      no_op;
        logic                      reg_write_enable;
        logic                      mem_read;
        logic                      mem_write;
        opcode_e                   alu_op;
        logic [`DATA_WIDTH-1:0]    operand_1;
        logic [`DATA_WIDTH-1:0]    operand_2;   // immediate when use_imm
        logic [`DATA_WIDTH-1:0]    store_data;  // rs2 value
        logic [`REG_IDX_WIDTH-1:0] reg_1_idx;
        logic [`REG_IDX_WIDTH-1:0] reg_2_idx;
        logic [`REG_IDX_WIDTH-1:0] reg_dest_idx;
        logic                      use_imm;
    } id_ex_t;

    typedef struct packed {
        logic                      no_op;
        logic                      reg_write_enable;
        logic                      mem_read;
        logic                      mem_write;
        logic [`DATA_WIDTH-1:0]    alu_result;  // also the load/store address
        logic [`DATA_WIDTH-1:0]    store_data;
        logic [`REG_IDX_WIDTH-1:0] reg_dest_idx;
    } ex_mem_t;

    typedef struct packed {
        logic                      valid;
        logic [`REG_IDX_WIDTH-1:0] dest;
        logic [`DATA_WIDTH-1:0]    data;
    } wb_t;

endpackage

// ==== design/instr_queue.sv ====
`include "pipe_config.svh"
`timescale 1ns/1ps

module instr_queue (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,      // credited push from sender
    input  pipe_pkg::instr_t in_instr,
    input  logic             q_pop,
    output logic             q_valid,
    output pipe_pkg::instr_t q_instr,
    output logic             in_credit      // one pulse per pop
);
    import pipe_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    instr_t           fifo_mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             full, push, pop;

    assign full    = (count == `QUEUE_DEPTH);
    assign push    = in_valid & ~full;          // overflow dropped, checker flags it
    assign pop     = q_pop & q_valid;
    assign q_valid = (count != '0);
    assign q_instr = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push)
            fifo_mem[wr_ptr] <= in_instr;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count     <= count + push - pop;
            in_credit <= pop;                   // credit returns the cycle after the pop
        end
    end

endmodule

// ==== design/decode_stage.sv ====
`include "pipe_config.svh"
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      q_valid,
    input  pipe_pkg::instr_t          q_instr,
    input  logic                      stall,     // load-use hold
    input  pipe_pkg::wb_t             wb,        // retiring write
    output logic                      q_pop,
    output pipe_pkg::id_ex_t          id_pkt,
    output logic [`REG_IDX_WIDTH-1:0] id_rs1,
    output logic [`REG_IDX_WIDTH-1:0] id_rs2
);
    import pipe_pkg::*;

    instr_t                 dec_instr;           // decode register
    logic                   dec_valid;
    logic [`DATA_WIDTH-1:0] regs [1 << `REG_IDX_WIDTH];
    logic [`DATA_WIDTH-1:0] rd_data_1, rd_data_2;
    logic [`DATA_WIDTH-1:0] imm_ext;

    assign q_pop   = q_valid & ~stall;
    assign id_rs1  = dec_instr.rs1;
    assign id_rs2  = dec_instr.rs2;
    assign imm_ext = {{(`DATA_WIDTH - `IMM_WIDTH){dec_instr.imm[`IMM_WIDTH-1]}}, dec_instr.imm};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec_instr <= '0;
        end else if (!stall) begin
            dec_valid <= q_valid;
            dec_instr <= q_valid ? q_instr : '0;    // empty queue loads a nop
        end
    end

    // r0 is never written, wb.valid excludes dest 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `REG_IDX_WIDTH); i++)
                regs[i] <= '0;
        end else if (wb.valid) begin
            regs[wb.dest] <= wb.data;
        end
    end

    function automatic logic [`DATA_WIDTH-1:0] read_reg(input logic [`REG_IDX_WIDTH-1:0] idx);
        if (idx == '0)
            return '0;
        if (wb.valid && wb.dest == idx)
            return wb.data;                         // write-through in the same cycle
        return regs[idx];
    endfunction

    always_comb begin
        rd_data_1           = read_reg(dec_instr.rs1);
        rd_data_2           = read_reg(dec_instr.rs2);
        id_pkt              = '0;
        id_pkt.no_op        = 1'b1;
        id_pkt.alu_op       = dec_instr.opcode;
        id_pkt.reg_1_idx    = dec_instr.rs1;
        id_pkt.reg_2_idx    = dec_instr.rs2;
        id_pkt.reg_dest_idx = dec_instr.rd;
        if (dec_valid) begin
            case (dec_instr.opcode)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
                    id_pkt.no_op            = 1'b0;
                    id_pkt.reg_write_enable = 1'b1;
                end
                OP_ADDI, OP_LW: begin
                    id_pkt.no_op            = 1'b0;
                    id_pkt.reg_write_enable = 1'b1;
                    id_pkt.use_imm          = 1'b1;
                    id_pkt.mem_read         = (dec_instr.opcode == OP_LW);
                end
                OP_SW: begin
                    id_pkt.no_op     = 1'b0;
                    id_pkt.use_imm   = 1'b1;    // address is rs1 + imm
                    id_pkt.mem_write = 1'b1;
                end
                default: ;                      // nop and spare codes stay a bubble
            endcase
        end
        id_pkt.operand_1  = rd_data_1;
        id_pkt.operand_2  = id_pkt.use_imm ? imm_ext : rd_data_2;
        id_pkt.store_data = rd_data_2;
    end

endmodule

// ==== design/hazard_unit.sv ====
`include "pipe_config.svh"
`timescale 1ns/1ps

module hazard_unit (
    input  logic [`REG_IDX_WIDTH-1:0] id_rs1,
    input  logic [`REG_IDX_WIDTH-1:0] id_rs2,
    input  logic                      id_uses_rs2,
    input  pipe_pkg::id_ex_t          ex_pkt,
    input  pipe_pkg::ex_mem_t         mem_pkt,
    output pipe_pkg::hazd_ctl_e       hazd_ctl,
    output logic                      stall,
    output pipe_pkg::fwd_sel_e        fwd_sel_1,
    output pipe_pkg::fwd_sel_e        fwd_sel_2
);
    import pipe_pkg::*;

    logic ex_writes, mem_writes, ex_load;

    // once decode advances, ex_pkt sits in ex_mem and mem_pkt in mem_wb
    assign ex_writes  = ex_pkt.reg_write_enable & ~ex_pkt.no_op;
    assign mem_writes = mem_pkt.reg_write_enable & ~mem_pkt.no_op;
    assign ex_load    = ex_pkt.mem_read & ~ex_pkt.no_op & (ex_pkt.reg_dest_idx != '0);

    assign stall    = ex_load & ((ex_pkt.reg_dest_idx == id_rs1) |
                                 (id_uses_rs2 & (ex_pkt.reg_dest_idx == id_rs2)));
    assign hazd_ctl = stall ? HAZD_NO_OP : HAZD_NORMAL;

    function automatic fwd_sel_e pick_src(input logic [`REG_IDX_WIDTH-1:0] idx);
        if (idx == '0)
            return FWD_ID_EX;                   // r0 is never forwarded
        if (ex_writes && ex_pkt.reg_dest_idx == idx)
            return FWD_EX_MEM;                  // newest writer wins
        if (mem_writes && mem_pkt.reg_dest_idx == idx)
            return FWD_MEM_WB;
        return FWD_ID_EX;
    endfunction

    always_comb begin
        fwd_sel_1 = pick_src(id_rs1);
        fwd_sel_2 = pick_src(id_rs2);
    end

endmodule

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::hazd_ctl_e hazd_ctl,   // next-state order from hazard_unit
    input  pipe_pkg::id_ex_t    id_pkt,     // decoded packet
    output pipe_pkg::id_ex_t    ex_pkt      // to ex_stage and hazard_unit
);
    import pipe_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_pkt       <= '0;
            ex_pkt.no_op <= 1'b1;
        end else begin
            case (hazd_ctl)
                HAZD_NO_OP: begin
                    // bubble, payload left as is
                    ex_pkt.no_op            <= 1'b1;
                    ex_pkt.reg_write_enable <= 1'b0;
                    ex_pkt.mem_write        <= 1'b0;
                    ex_pkt.mem_read         <= 1'b0;   // keeps the load from stalling twice
                end
                default: ex_pkt <= id_pkt;            // HAZD_NORMAL
            endcase
        end
    end

endmodule

// ==== design/ex_stage.sv ====
`include "pipe_config.svh"
`timescale 1ns/1ps

module ex_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::id_ex_t   ex_pkt,
    input  pipe_pkg::fwd_sel_e fwd_sel_1,    // chosen while the instruction was in decode
    input  pipe_pkg::fwd_sel_e fwd_sel_2,
    input  pipe_pkg::ex_mem_t  mem_pkt_fwd,  // ex_mem register fed back
    input  pipe_pkg::wb_t      wb,
    output pipe_pkg::ex_mem_t  mem_pkt
);
    import pipe_pkg::*;

    fwd_sel_e               sel_1_q, sel_2_q;   // aligned with id_ex
    logic [`DATA_WIDTH-1:0] src_1, src_2, alu_b, alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_1_q <= FWD_ID_EX;
            sel_2_q <= FWD_ID_EX;
        end else begin
            sel_1_q <= fwd_sel_1;
            sel_2_q <= fwd_sel_2;
        end
    end

    function automatic logic [`DATA_WIDTH-1:0] fwd_mux(input fwd_sel_e sel,
                                                       input logic [`DATA_WIDTH-1:0] own);
        case (sel)
            FWD_EX_MEM: return mem_pkt_fwd.alu_result;  // never a load, hazard stalls those
            FWD_MEM_WB: return wb.data;
            default:    return own;
        endcase
    endfunction

    always_comb begin
        src_1 = fwd_mux(sel_1_q, ex_pkt.operand_1);
        src_2 = fwd_mux(sel_2_q, ex_pkt.store_data);
        alu_b = ex_pkt.use_imm ? ex_pkt.operand_2 : src_2;
        case (ex_pkt.alu_op)
            OP_ADD, OP_ADDI, OP_LW, OP_SW: alu_result = src_1 + alu_b;  // wraps
            OP_SUB: alu_result = src_1 - alu_b;
            OP_AND: alu_result = src_1 & alu_b;
            OP_OR:  alu_result = src_1 | alu_b;
            OP_XOR: alu_result = src_1 ^ alu_b;
            OP_SLT: alu_result = {{(`DATA_WIDTH-1){1'b0}}, $signed(src_1) < $signed(alu_b)};
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_pkt       <= '0;
            mem_pkt.no_op <= 1'b1;
        end else begin
            mem_pkt.no_op            <= ex_pkt.no_op;
            mem_pkt.reg_write_enable <= ex_pkt.reg_write_enable;
            mem_pkt.mem_read         <= ex_pkt.mem_read;
            mem_pkt.mem_write        <= ex_pkt.mem_write;
            mem_pkt.alu_result       <= alu_result;
            mem_pkt.store_data       <= src_2;       // forwarded rs2
            mem_pkt.reg_dest_idx     <= ex_pkt.reg_dest_idx;
        end
    end

endmodule

// ==== design/mem_stage.sv ====
`include "pipe_config.svh"
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::ex_mem_t mem_pkt,
    output pipe_pkg::wb_t     wb           // retirement record
);
    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    logic [`DATA_WIDTH-1:0] dmem [`DMEM_WORDS];
    logic [ADDR_W-1:0]      addr;
    logic [`DATA_WIDTH-1:0] load_data;
    logic                   do_store;

    assign addr      = mem_pkt.alu_result[ADDR_W-1:0];   // word address mod DMEM_WORDS
    assign load_data = dmem[addr];
    assign do_store  = mem_pkt.mem_write & ~mem_pkt.no_op;

    // memory comes out of reset zeroed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++)
                dmem[i] <= '0;
        end else if (do_store) begin
            dmem[addr] <= mem_pkt.store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= mem_pkt.reg_write_enable & ~mem_pkt.no_op &
                        (mem_pkt.reg_dest_idx != '0);    // r0 writes retire silently
            wb.dest  <= mem_pkt.reg_dest_idx;
            wb.data  <= mem_pkt.mem_read ? load_data : mem_pkt.alu_result;
        end
    end

endmodule

// ==== design/pipe_top.sv ====
`include "pipe_config.svh"
`timescale 1ns/1ps

module pipe_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  pipe_pkg::instr_t in_instr,
    output logic             in_credit,
    output pipe_pkg::wb_t    wb_out       // also feeds regfile and forwarding
);
    import pipe_pkg::*;

    logic                      q_valid, q_pop, stall, id_uses_rs2;
    instr_t                    q_instr;
    id_ex_t                    id_pkt, ex_pkt;
    ex_mem_t                   mem_pkt;
    hazd_ctl_e                 hazd_ctl;
    fwd_sel_e                  fwd_sel_1, fwd_sel_2;
    logic [`REG_IDX_WIDTH-1:0] id_rs1, id_rs2;

    // rs2 matters for register-register ops and as store data
    assign id_uses_rs2 = ~id_pkt.use_imm | id_pkt.mem_write;

    instr_queue u_instr_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .q_pop     (q_pop),
        .q_valid   (q_valid),
        .q_instr   (q_instr),
        .in_credit (in_credit)
    );

    decode_stage u_decode_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .q_valid (q_valid),
        .q_instr (q_instr),
        .stall   (stall),
        .wb      (wb_out),
        .q_pop   (q_pop),
        .id_pkt  (id_pkt),
        .id_rs1  (id_rs1),
        .id_rs2  (id_rs2)
    );

    hazard_unit u_hazard_unit (
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_uses_rs2 (id_uses_rs2),
        .ex_pkt      (ex_pkt),
        .mem_pkt     (mem_pkt),
        .hazd_ctl    (hazd_ctl),
        .stall       (stall),
        .fwd_sel_1   (fwd_sel_1),
        .fwd_sel_2   (fwd_sel_2)
    );

    id_ex_reg u_id_ex_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .hazd_ctl (hazd_ctl),
        .id_pkt   (id_pkt),
        .ex_pkt   (ex_pkt)
    );

    ex_stage u_ex_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_pkt      (ex_pkt),
        .fwd_sel_1   (fwd_sel_1),
        .fwd_sel_2   (fwd_sel_2),
        .mem_pkt_fwd (mem_pkt),
        .wb          (wb_out),
        .mem_pkt     (mem_pkt)
    );

    mem_stage u_mem_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_pkt (mem_pkt),
        .wb      (wb_out)
    );

endmodule

// ==== tests/pipe_checker.sv ====
`timescale 1ns/1ps

module pipe_checker (
    input logic          clk,
    input logic          rst_n,
    input logic          in_valid,
    input logic          in_credit,
    input logic          q_full,      // queue full flag
    input logic          q_pop,
    input logic          q_valid,
    input logic          stall,
    input pipe_pkg::wb_t wb_out
);
    int fail_count = 0;               // read by the testbench at the end

    // a credited sender never finds the queue full
    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> !q_full)
        else begin
            $error("push into a full instruction queue");
            fail_count++;
        end

    // each credit cycle follows a real pop
    assert property (@(posedge clk) disable iff (!rst_n) in_credit |-> $past(q_pop & q_valid))
        else begin
            $error("credit returned without a pop in the cycle before");
            fail_count++;
        end

    // one bubble per load-use
    assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
        else begin
            $error("stall held for two consecutive cycles");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) wb_out.valid |-> wb_out.dest != '0)
        else begin
            $error("writeback record carries destination r0");
            fail_count++;
        end

endmodule

bind pipe_top pipe_checker u_pipe_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_credit (in_credit),
    .q_full    (u_instr_queue.full),
    .q_pop     (q_pop),
    .q_valid   (q_valid),
    .stall     (stall),
    .wb_out    (wb_out)
);

// ==== tests/pipe_tb.sv ====
`include "pipe_config.svh"
`timescale 1ns/1ps

module pipe_tb;
    import pipe_pkg::*;

    localparam int MAX_LINES    = 64;
    localparam int DRAIN_CYCLES = 8;        // in-pipeline latency plus a stall, with margin

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    instr_t      in_instr;
    logic        in_credit;
    wb_t         wb_out;

    logic [75:0] raw [MAX_LINES];           // test id, expect flag, dest, data, instruction
    instr_t      instr_mem [MAX_LINES];
    wb_t         exp_wb [MAX_LINES];        // in retirement order
    int          exp_test [MAX_LINES];
    int          n_instr, n_exp;
    int          value_errors, other_errors, assert_errors;
    int          seed;
    logic        timed_out;

    pipe_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_credit (in_credit),
        .wb_out    (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;             // 40 ns period
    end

    function automatic string test_name(input int id);
        case (id)
            1: return "alu_ops";
            2: return "forwarding";
            3: return "load_use";
            4: return "r0_no_write";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_wb(input string name, input wb_t expected, input wb_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail %s: expected r%0d=%h, actual r%0d=%h", name,
                     expected.dest, expected.data, actual.dest, actual.data);
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic load_tests();
        $readmemh("tests/pipe_tests.txt", raw);
        n_instr = 0;
        n_exp   = 0;
        while (n_instr < MAX_LINES && !$isunknown(raw[n_instr])) begin
            instr_mem[n_instr] = raw[n_instr][31:0];
            if (raw[n_instr][71:68] != 4'h0) begin     // instruction retires a record
                exp_wb[n_exp]   = {1'b1, raw[n_instr][66:64], raw[n_instr][63:32]};
                exp_test[n_exp] = raw[n_instr][75:72];
                n_exp++;
            end
            n_instr++;
        end
    endtask

    task automatic take_wb(inout int got);
        if (wb_out.valid) begin
            if (got < n_exp) begin
                check_wb(test_name(exp_test[got]), exp_wb[got], wb_out);
            end else begin
                other_errors++;
                $display("extra writeback record to r%0d with data %h", wb_out.dest, wb_out.data);
            end
            got++;
        end
    endtask

    // reset, then push the whole program under credit control
    task automatic run_pass(input string label, input logic use_gaps);
        int          sent;
        int          got;
        int          gap;
        int          credits;
        int          cycles;
        int          limit;
        logic [31:0] r;
        sent     = 0;
        got      = 0;
        gap      = 0;
        credits  = `QUEUE_DEPTH;            // queue starts empty
        cycles   = 0;
        limit    = 8 * n_instr + 50;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        while ((sent < n_instr || got < n_exp) && !timed_out) begin
            @(negedge clk);
            cycles++;
            take_wb(got);
            if (in_credit)
                credits++;                  // one slot freed per pulse
            in_valid = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (sent < n_instr && credits > 0) begin
                in_valid = 1'b1;
                in_instr = instr_mem[sent];
                sent++;
                credits--;
                if (use_gaps) begin
                    r   = $random(seed);
                    gap = r[2] ? 0 : r[1:0];    // about half the pushes back to back
                end
            end
            if (cycles >= limit) begin
                timed_out = 1'b1;
                other_errors++;
                $display("timeout in %s pass, %0d of %0d records seen after %0d cycles",
                         label, got, n_exp, cycles);
            end
        end
        repeat (DRAIN_CYCLES) begin         // catch late extras and the last credits
            @(negedge clk);
            in_valid = 1'b0;
            take_wb(got);
            if (in_credit)
                credits++;
        end
        check_count({label, " record count"}, n_exp, got);
        check_count({label, " credits returned"}, `QUEUE_DEPTH, credits);
    endtask

    initial begin
        seed          = 32'h6ef3_8ef0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_instr      = '0;
        value_errors  = 0;
        other_errors  = 0;
        assert_errors = 0;
        timed_out     = 1'b0;
        load_tests();
        if (n_exp == 0) begin
            other_errors++;
            $display("no expected records could be read from the test file");
        end
        run_pass("full_rate", 1'b0);
        if (!timed_out)
            run_pass("random_gaps", 1'b1);
        assert_errors = DUT.u_pipe_checker.fail_count;
        $display("errors: %0d wrong values, %0d other, %0d assertions",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== tests/pipe_tests.txt ====
// columns: test id, wb expected, dest, data, instruction word
// test ids: 1 alu ops, 2 forwarding, 3 load-use, 4 r0 and non-writing
1_1_1_00000064_72000064 // addi r1, r0, 100
1_1_2_FFFFFFF9_7400FFF9 // addi r2, r0, -7
1_1_3_0000006B_26500000 // sub  r3, r1, r2
1_1_4_00000060_38500000 // and  r4, r1, r2
1_1_5_FFFFFFFD_4A500000 // or   r5, r1, r2
1_1_6_FFFFFF9D_5C500000 // xor  r6, r1, r2
1_1_7_00000001_6E880000 // slt  r7, r2, r1
1_1_7_00000000_6E500000 // slt  r7, r1, r2
2_1_3_000000D6_16D80000 // add  r3, r3, r3
2_1_3_00000072_26C80000 // sub  r3, r3, r1
2_1_1_00000065_72400001 // addi r1, r1, 1
2_1_2_000000D7_14C80000 // add  r2, r3, r1
2_1_5_00000000_7B400003 // addi r5, r5, 3
3_0_0_00000000_90100045 // sw   r2, 0x45(r0)
3_1_4_000000D7_8840FFA0 // lw   r4, -96(r1)
3_1_6_000001AE_1D200000 // add  r6, r4, r4
3_0_0_00000000_9130FF2F // sw   r6, -209(r4)
3_1_1_000001AE_82000046 // lw   r1, 0x46(r0)
3_1_2_FFFFFE52_24080000 // sub  r2, r0, r1
4_0_0_00000000_70001234 // addi r0, r0, 0x1234
4_1_4_00000000_48000000 // or   r4, r0, r0
4_0_0_00000000_00000000 // nop
4_0_0_00000000_80000006 // lw   r0, 6(r0)
4_1_6_000001AE_1C080000 // add  r6, r0, r1

// ==== all.f ====
+incdir+design
design/pipe_pkg.sv
design/instr_queue.sv
design/decode_stage.sv
design/hazard_unit.sv
design/id_ex_reg.sv
design/ex_stage.sv
design/mem_stage.sv
design/pipe_top.sv
tests/pipe_checker.sv
tests/pipe_tb.sv

// ==== Bender.yml ====
package:
  name: pipe_slice

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/pipe_pkg.sv
      - design/instr_queue.sv
      - design/decode_stage.sv
      - design/hazard_unit.sv
      - design/id_ex_reg.sv
      - design/ex_stage.sv
      - design/mem_stage.sv
      - design/pipe_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/pipe_checker.sv
      - tests/pipe_tb.sv
